// ==== aes_cfg.svh ====
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// byte addresses of the register map
`define AES_ADDR_CTRL        32'h0000_0000
`define AES_ADDR_START       32'h0000_0004
`define AES_ADDR_STATUS      32'h0000_0008
`define AES_ADDR_BLOCK_BASE  32'h0000_0010
`define AES_ADDR_KEY_BASE    32'h0000_0050
`define AES_ADDR_RESULT_BASE 32'h0000_0090

`define AES_STATUS_IDLE_BIT  0
`define AES_STATUS_DONE_BIT  1

`define AES_ROUNDS           10
`define AES_NUM_SLOTS        4   // each slot spans 16 bytes in every region

`endif

// ==== aes_reg_pkg.sv ====
`include "aes_cfg.svh"

package aes_reg_pkg;

    typedef struct packed {
        logic        cs;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    // done sits above idle, matching the STATUS bit order
    typedef struct packed {
        logic done;
        logic idle;
    } status_t;

    typedef logic [`AES_NUM_SLOTS-1:0] slot_mask_t;

endpackage

// ==== aes_cipher_pkg.sv ====
package aes_cipher_pkg;

    typedef logic [127:0] block_t;  // byte 0 of the AES state is bits 127:120
    typedef logic [127:0] key_t;

    typedef struct packed {
        key_t   key;
        block_t block;
    } slot_job_t;

    localparam logic [2047:0] SBOX = {
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16
    };

    function automatic logic [7:0] sbox(input logic [7:0] b);
        return SBOX[2047 - 8 * int'(b) -: 8];
    endfunction

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic block_t sub_bytes(input block_t s);
        block_t r;
        for (int i = 0; i < 16; i++) begin
            r[127 - 8*i -: 8] = sbox(s[127 - 8*i -: 8]);
        end
        return r;
    endfunction

    // row r of the state is rotated left by r columns
    function automatic block_t shift_rows(input block_t s);
        block_t r;
        for (int row = 0; row < 4; row++) begin
            for (int col = 0; col < 4; col++) begin
                r[127 - 8*(row + 4*col) -: 8] = s[127 - 8*(row + 4*((col + row) % 4)) -: 8];
            end
        end
        return r;
    endfunction

    function automatic block_t mix_columns(input block_t s);
        block_t     r;
        logic [7:0] a0, a1, a2, a3;
        for (int c = 0; c < 4; c++) begin
            a0 = s[127 - 32*c -: 8];
            a1 = s[119 - 32*c -: 8];
            a2 = s[111 - 32*c -: 8];
            a3 = s[103 - 32*c -: 8];
            r[127 - 32*c -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            r[119 - 32*c -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            r[111 - 32*c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            r[103 - 32*c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
        return r;
    endfunction

    // rcon doubles in GF(2^8) from 01 at round 1
    function automatic logic [7:0] round_const(input logic [3:0] rnd);
        logic [7:0] rc;
        rc = 8'h01;
        for (int i = 2; i <= 10; i++) begin
            if (i <= int'(rnd)) rc = xtime(rc);
        end
        return rc;
    endfunction

    function automatic key_t next_round_key(input key_t k, input logic [3:0] rnd);
        logic [31:0] w0, w1, w2, w3, t;
        w0 = k[127:96];
        w1 = k[95:64];
        w2 = k[63:32];
        w3 = k[31:0];
        t  = {sbox(w3[23:16]), sbox(w3[15:8]), sbox(w3[7:0]), sbox(w3[31:24])};
        w0 = w0 ^ t ^ {round_const(rnd), 24'h0};
        w1 = w1 ^ w0;
        w2 = w2 ^ w1;
        w3 = w3 ^ w2;
        return {w0, w1, w2, w3};
    endfunction

endpackage

// ==== aes_core.sv ====
`include "aes_cfg.svh"

module aes_core (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      go_i,
    input  aes_cipher_pkg::slot_job_t job_i,
    output aes_cipher_pkg::block_t    result_o,
    output logic                      result_valid_o
);
    import aes_cipher_pkg::*;

    localparam logic [3:0] LAST_ROUND = 4'(`AES_ROUNDS);

    block_t     state_q;
    key_t       rkey_q;
    logic [3:0] round_q;    // round applied at the next edge, 0 while idle
    logic       valid_q;
    key_t       rkey_next;
    block_t     round_out;

    always_comb begin
        rkey_next = next_round_key(rkey_q, round_q);
        round_out = shift_rows(sub_bytes(state_q));
        if (round_q != LAST_ROUND) begin
            round_out = mix_columns(round_out);
        end
        round_out = round_out ^ rkey_next;
    end

    always_ff @(posedge clk_i) begin
        if (go_i) begin
            state_q <= job_i.block ^ job_i.key;    // initial AddRoundKey
            rkey_q  <= job_i.key;
        end else if (round_q != '0) begin
            state_q <= round_out;
            rkey_q  <= rkey_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            round_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= (round_q == LAST_ROUND);
            if (go_i) begin
                round_q <= 4'd1;
            end else if (round_q == LAST_ROUND) begin
                round_q <= '0;
            end else if (round_q != '0) begin
                round_q <= round_q + 4'd1;
            end
        end
    end

    assign result_o       = state_q;
    assign result_valid_o = valid_q;

    // a new job may only start once the previous one has left the rounds
    a_go_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        go_i |-> round_q == '0);

endmodule

// ==== aes_slot_seq.sv ====
`include "aes_cfg.svh"

module aes_slot_seq (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      start_i,
    input  aes_reg_pkg::slot_mask_t   mask_i,
    input  aes_cipher_pkg::slot_job_t jobs_i [`AES_NUM_SLOTS],
    output logic                      busy_o,
    output logic                      done_set_o,
    output logic                      result_we_o,
    output logic [1:0]                result_slot_o,
    output aes_cipher_pkg::block_t    result_o
);
    import aes_cipher_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_SLOT0, S_SLOT1, S_SLOT2, S_SLOT3} state_e;

    state_e     state_q, state_d;
    logic       issued_q;
    logic [1:0] slot_idx;
    logic       go;
    logic       advance;
    logic       core_valid;
    slot_job_t  cur_job;

    assign slot_idx = 2'(state_q - S_SLOT0);
    assign cur_job  = jobs_i[slot_idx];

    always_comb begin
        state_d = state_q;
        go      = 1'b0;
        advance = 1'b0;
        if (state_q == S_IDLE) begin
            if (start_i) state_d = S_SLOT0;    // a start while busy never reaches here
        end else begin
            go = mask_i[slot_idx] && !issued_q;
            // once a job is out, wait for its result even if the mask changes
            advance = issued_q ? core_valid : !mask_i[slot_idx];
            if (advance) begin
                state_d = (state_q == S_SLOT3) ? S_IDLE : state_e'(state_q + 3'd1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q  <= S_IDLE;
            issued_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (advance) begin
                issued_q <= 1'b0;
            end else if (go) begin
                issued_q <= 1'b1;
            end
        end
    end

    aes_core u_core (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .go_i           (go),
        .job_i          (cur_job),
        .result_o       (result_o),
        .result_valid_o (core_valid)
    );

    assign busy_o        = (state_q != S_IDLE);
    assign done_set_o    = advance && (state_q == S_SLOT3);
    assign result_we_o   = core_valid;
    assign result_slot_o = slot_idx;

    // the core only finishes jobs that this machine handed out during a run
    a_result_in_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_we_o |-> state_q != S_IDLE);

endmodule

// ==== aes_regs.sv ====
`include "aes_cfg.svh"

module aes_regs (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  aes_reg_pkg::bus_req_t     bus_req_i,
    output logic [31:0]               rdata_o,
    input  logic                      busy_i,
    input  logic                      done_set_i,
    input  logic                      result_we_i,
    input  logic [1:0]                result_slot_i,
    input  aes_cipher_pkg::block_t    result_i,
    output logic                      start_o,
    output aes_reg_pkg::slot_mask_t   mask_o,
    output aes_cipher_pkg::slot_job_t jobs_o [`AES_NUM_SLOTS],
    input  logic                      clear_irq_i,
    output logic                      irq_o
);
    import aes_reg_pkg::*;
    import aes_cipher_pkg::*;

    localparam logic [31:0] REGION_SPAN = 32'(16 * `AES_NUM_SLOTS);

    slot_mask_t  mask_q;
    slot_job_t   jobs_q [`AES_NUM_SLOTS];
    block_t      results_q [`AES_NUM_SLOTS];
    logic        done_q;
    logic        irq_q;
    status_t     status;
    logic        wr, rd;
    logic [31:0] blk_off, key_off, res_off;
    logic        in_block, in_key, in_result;
    logic [1:0]  word_idx;
    logic        status_clr;

    assign wr = bus_req_i.cs && bus_req_i.we;
    assign rd = bus_req_i.cs && !bus_req_i.we;

    // addresses below a base wrap to large offsets and fall out of range
    assign blk_off   = bus_req_i.addr - `AES_ADDR_BLOCK_BASE;
    assign key_off   = bus_req_i.addr - `AES_ADDR_KEY_BASE;
    assign res_off   = bus_req_i.addr - `AES_ADDR_RESULT_BASE;
    assign in_block  = blk_off < REGION_SPAN;
    assign in_key    = key_off < REGION_SPAN;
    assign in_result = res_off < REGION_SPAN;
    assign word_idx  = bus_req_i.addr[3:2];    // word 0 is the most significant

    assign start_o    = wr && (bus_req_i.addr == `AES_ADDR_START) && bus_req_i.wdata[0];
    assign status_clr = wr && (bus_req_i.addr == `AES_ADDR_STATUS)
                        && !bus_req_i.wdata[`AES_STATUS_DONE_BIT];

    always_ff @(posedge clk_i) begin
        if (wr && in_block) begin
            jobs_q[blk_off[5:4]].block[127 - 32*int'(word_idx) -: 32] <= bus_req_i.wdata;
        end
        if (wr && in_key) begin
            jobs_q[key_off[5:4]].key[127 - 32*int'(word_idx) -: 32] <= bus_req_i.wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            mask_q <= '0;
            done_q <= 1'b0;
            irq_q  <= 1'b0;
            for (int i = 0; i < `AES_NUM_SLOTS; i++) begin
                results_q[i] <= '0;
            end
        end else begin
            irq_q <= done_q;
            if (wr && bus_req_i.addr == `AES_ADDR_CTRL) begin
                mask_q <= bus_req_i.wdata[`AES_NUM_SLOTS-1:0];
            end
            if (result_we_i) begin
                results_q[result_slot_i] <= result_i;
            end
            if (clear_irq_i) begin
                done_q <= 1'b0;    // held clear for as long as the level stays high
            end else if (done_set_i) begin
                done_q <= 1'b1;
            end else if (start_o || status_clr) begin
                done_q <= 1'b0;
            end
        end
    end

    assign status = '{done: done_q, idle: !busy_i};

    always_comb begin
        rdata_o = '0;
        if (rd) begin
            if (bus_req_i.addr == `AES_ADDR_CTRL) begin
                rdata_o = 32'(mask_q);
            end else if (bus_req_i.addr == `AES_ADDR_STATUS) begin
                rdata_o[`AES_STATUS_IDLE_BIT] = status.idle;
                rdata_o[`AES_STATUS_DONE_BIT] = status.done;
            end else if (in_result) begin
                rdata_o = results_q[res_off[5:4]][127 - 32*int'(word_idx) -: 32];
            end
        end
    end

    assign mask_o = mask_q;
    assign jobs_o = jobs_q;
    assign irq_o  = irq_q;

    // done can only come from the sequencer finishing slot 3 two edges earlier
    a_irq_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(irq_o) |-> $past(done_set_i, 2));

endmodule

// ==== aes.sv ====
`include "aes_cfg.svh"

module aes (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  aes_reg_pkg::bus_req_t bus_req_i,
    output logic [31:0]           rdata_o,
    output logic                  irq_o,
    input  logic                  clear_irq_i
);
    import aes_reg_pkg::*;
    import aes_cipher_pkg::*;

    logic       start;
    slot_mask_t mask;
    slot_job_t  jobs [`AES_NUM_SLOTS];
    logic       busy;
    logic       done_set;
    logic       result_we;
    logic [1:0] result_slot;
    block_t     result;

    aes_regs u_regs (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .bus_req_i     (bus_req_i),
        .rdata_o       (rdata_o),
        .busy_i        (busy),
        .done_set_i    (done_set),
        .result_we_i   (result_we),
        .result_slot_i (result_slot),
        .result_i      (result),
        .start_o       (start),
        .mask_o        (mask),
        .jobs_o        (jobs),
        .clear_irq_i   (clear_irq_i),
        .irq_o         (irq_o)
    );

    aes_slot_seq u_seq (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .start_i       (start),
        .mask_i        (mask),
        .jobs_i        (jobs),
        .busy_o        (busy),
        .done_set_o    (done_set),
        .result_we_o   (result_we),
        .result_slot_o (result_slot),
        .result_o      (result)
    );

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (5) @(posedge clk_o);
        #1 rst_no = 1'b1;    // released just after the fifth edge
    end

endmodule

// ==== tb_aes.sv ====
`include "aes_cfg.svh"

module tb_aes;
    import aes_reg_pkg::*;
    import aes_cipher_pkg::*;

    localparam int NUM_RUNS   = 20;
    // bus writes, control, result reads and a full four-slot run per pass
    localparam int RUN_CYCLES = 8 * `AES_NUM_SLOTS + 2 + 4 * `AES_NUM_SLOTS
                                + `AES_NUM_SLOTS * (`AES_ROUNDS + 3) + 8;
    localparam int MAX_CYCLES = 2 * (NUM_RUNS + 3) * RUN_CYCLES;
    localparam logic [31:0] SEED        = 32'h93df_62d9;
    localparam logic [31:0] STATUS_IDLE = 32'd1 << `AES_STATUS_IDLE_BIT;
    localparam logic [31:0] STATUS_DONE = 32'd1 << `AES_STATUS_DONE_BIT;

    // FIPS-197 appendix B example
    localparam key_t   FIPS_KEY = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c;
    localparam block_t FIPS_PT  = 128'h3243f6a8_885a308d_313198a2_e0370734;
    localparam block_t FIPS_CT  = 128'h3925841d_02dc09fb_dc118597_196a0b32;

    logic        clk;
    logic        rst_n;
    bus_req_t    bus_req;
    logic [31:0] rdata;
    logic        irq;
    logic        clear_irq;
    logic [31:0] lfsr_q;
    block_t      expected [`AES_NUM_SLOTS];
    int          errors;
    int          cycles;

    tb_clk_gen u_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    aes u_dut (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .bus_req_i   (bus_req),
        .rdata_o     (rdata),
        .irq_o       (irq),
        .clear_irq_i (clear_irq)
    );

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int nbits, output logic [127:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[126:0], lfsr_q[0]};
        end
    endtask

    function automatic block_t encrypt_block(input key_t key, input block_t pt);
        block_t s;
        key_t   k;
        s = pt ^ key;
        k = key;
        for (int rnd = 1; rnd <= `AES_ROUNDS; rnd++) begin
            k = next_round_key(k, 4'(rnd));
            s = shift_rows(sub_bytes(s));
            if (rnd != `AES_ROUNDS) s = mix_columns(s);    // the last round has no MixColumns
            s = s ^ k;
        end
        return s;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // every bus task starts and ends 1 time unit after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        bus_req = '{cs: 1'b1, we: 1'b1, addr: addr, wdata: data};
        idle_cycles(1);
        bus_req = '0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_req = '{cs: 1'b1, we: 1'b0, addr: addr, wdata: 32'h0};
        #1 data = rdata;
        idle_cycles(1);
        bus_req = '0;
    endtask

    task automatic load_slot(input int slot, input key_t key, input block_t blk);
        for (int w = 0; w < 4; w++) begin
            bus_write(`AES_ADDR_BLOCK_BASE + 32'(16 * slot + 4 * w), blk[127 - 32*w -: 32]);
            bus_write(`AES_ADDR_KEY_BASE + 32'(16 * slot + 4 * w), key[127 - 32*w -: 32]);
        end
    endtask

    task automatic start_run(input slot_mask_t mask);
        logic [31:0] st;
        bus_write(`AES_ADDR_CTRL, 32'(mask));
        bus_write(`AES_ADDR_START, 32'h1);
        st = '0;
        while (!st[`AES_STATUS_DONE_BIT]) bus_read(`AES_ADDR_STATUS, st);
        check_word("STATUS", STATUS_IDLE | STATUS_DONE, st);
    endtask

    task automatic check_results;
        logic [31:0] word;
        for (int s = 0; s < `AES_NUM_SLOTS; s++) begin
            for (int w = 0; w < 4; w++) begin
                bus_read(`AES_ADDR_RESULT_BASE + 32'(16 * s + 4 * w), word);
                check_word($sformatf("RESULT[%0d][%0d]", s, w), expected[s][127 - 32*w -: 32], word);
            end
        end
    endtask

    // done is cleared either by the clear_irq_i level or by a STATUS write
    task automatic check_irq_clear(input logic by_pin);
        logic [31:0] st;
        check_word("irq_o", 32'h1, 32'(irq));
        if (by_pin) begin
            clear_irq = 1'b1;
            idle_cycles(2);
        end else begin
            bus_write(`AES_ADDR_STATUS, 32'h0);
            idle_cycles(1);
        end
        check_word("irq_o", 32'h0, 32'(irq));
        bus_read(`AES_ADDR_STATUS, st);
        check_word("STATUS", STATUS_IDLE, st);
        clear_irq = 1'b0;
    endtask

    task automatic random_run(input slot_mask_t mask, input logic by_pin);
        logic [127:0] key;
        logic [127:0] blk;
        for (int s = 0; s < `AES_NUM_SLOTS; s++) begin
            draw_bits(128, key);
            draw_bits(128, blk);
            load_slot(s, key, blk);
            if (mask[s]) expected[s] = encrypt_block(key, blk);    // disabled slots keep old results
        end
        start_run(mask);
        check_results();
        check_irq_clear(by_pin);
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [31:0]  st;
        logic [127:0] mask_bits;
        errors    = 0;
        lfsr_q    = SEED;
        bus_req   = '0;
        clear_irq = 1'b0;
        for (int s = 0; s < `AES_NUM_SLOTS; s++) expected[s] = '0;
        wait (rst_n === 1'b1);
        idle_cycles(1);

        bus_read(`AES_ADDR_STATUS, st);
        check_word("STATUS", STATUS_IDLE, st);
        check_word("irq_o", 32'h0, 32'(irq));
        check_results();

        load_slot(0, FIPS_KEY, FIPS_PT);
        expected[0] = FIPS_CT;
        start_run(4'b0001);
        check_results();
        check_irq_clear(1'b1);

        for (int run = 0; run < NUM_RUNS; run++) begin
            draw_bits(4, mask_bits);
            random_run(mask_bits[3:0], run[0]);
        end

        random_run(4'b0000, 1'b1);    // new jobs are loaded but none may land

        $display("tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
aes_reg_pkg.sv
aes_cipher_pkg.sv
aes_core.sv
aes_slot_seq.sv
aes_regs.sv
aes.sv
tb_clk_gen.sv
tb_aes.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_aes and check sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module tb_aes -f sources.f -o sim_aes
	./obj_dir/sim_aes | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
